// File: project.f
hdl/video_pkg.sv
hdl/tmds_pkg.sv
hdl/cmos_capture.sv
hdl/frame_buffer.sv
hdl/video_timing.sv
hdl/tmds_encoder.sv
hdl/tmds_serializer.sv
hdl/ov5640_hdmi.sv
tests/ov5640_hdmi_tb.sv

// File: Bender.yml
package:
  name: ov5640_hdmi

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - hdl/video_pkg.sv
      - hdl/tmds_pkg.sv
      - hdl/cmos_capture.sv
      - hdl/frame_buffer.sv
      - hdl/video_timing.sv
      - hdl/tmds_encoder.sv
      - hdl/tmds_serializer.sv
      - hdl/ov5640_hdmi.sv
  - target: test
    files:
      - tests/ov5640_hdmi_tb.sv

// File: tests/ov5640_hdmi_tb.sv
/* Directed testbench for the camera to HDMI path. Frames go in through the
   camera pins, TMDS symbols are rebuilt from the lanes and checked for tokens,
   raster shape, pixel values and DC balance on a tiny 8 by 4 frame */
`timescale 1ns/1ps
`default_nettype none

module ov5640_hdmi_tb;

    localparam int H_ACTIVE = 8;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 3;
    localparam int H_BACK   = 3;
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME    = H_TOTAL * V_TOTAL;    // Symbols per frame
    localparam int PIXELS   = H_ACTIVE * V_ACTIVE;
    localparam int WAIT_MAX = 50;                   // Pixel clocks without a symbol

    // One symbol per lane, taken in the same pixel period
    typedef struct packed {
        tmds_pkg::tmds_sym_t ch2;       // Red
        tmds_pkg::tmds_sym_t ch1;       // Green
        tmds_pkg::tmds_sym_t ch0;       // Blue, carries the syncs
    } sym_triple_t;

    logic       pixel_clk    = 1'b0;
    logic       pixel_clk_5x = 1'b0;
    logic       rst_n;
    logic       cam_vsync;
    logic       cam_href;
    logic [7:0] cam_data;
    logic       tmds_clk;
    logic [2:0] tmds_data;

    tmds_pkg::tmds_sym_t clk_bits;      // Last ten clock lane bits, oldest in bit 0
    tmds_pkg::tmds_sym_t lane_bits [3];
    sym_triple_t         sym_q [$];     // Aligned symbols from the monitor
    sym_triple_t         pending;       // Next symbol to be checked
    video_pkg::rgb565_t  image [PIXELS];
    int                  frame_lines;   // hsync pulses seen in the last frame
    int                  frame_active_lines;

    always #5 pixel_clk = ~pixel_clk;
    always #1 pixel_clk_5x = ~pixel_clk_5x;     // Edge aligned with pixel_clk

    ov5640_hdmi #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_ov5640_hdmi (
        .pixel_clk    (pixel_clk   ),
        .pixel_clk_5x (pixel_clk_5x),
        .rst_n        (rst_n       ),
        .cam_vsync    (cam_vsync   ),
        .cam_href     (cam_href    ),
        .cam_data     (cam_data    ),
        .tmds_clk     (tmds_clk    ),
        .tmds_data    (tmds_data   )
    );

    // ********************
    // Lane monitor
    // ********************

    // Mid-bit sampling, a symbol is complete when the clock lane shows 1111100000
    always @(posedge pixel_clk_5x or negedge pixel_clk_5x) begin
        #0.5;
        clk_bits = {tmds_clk, clk_bits[9:1]};
        for (int i = 0; i < 3; i++) begin
            lane_bits[i] = {tmds_data[i], lane_bits[i][9:1]};
        end
        if (clk_bits == 10'b00000_11111) begin
            sym_q.push_back(sym_triple_t'{ch2: lane_bits[2], ch1: lane_bits[1],
                                          ch0: lane_bits[0]});
        end
    end

    // ********************
    // Reference rules
    // ********************

    function automatic int find_token(input tmds_pkg::tmds_sym_t s);
        int idx;
        idx = -1;                       // Not a control token
        for (int i = 0; i < 4; i++) begin
            if (s === tmds_pkg::CTRL_TOKEN[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic int count_ones(input tmds_pkg::tmds_sym_t s);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++) begin
            n += int'(s[i]);
        end
        return n;
    endfunction

    // Inverse TMDS rule
    function automatic logic [7:0] decode_byte(input tmds_pkg::tmds_sym_t s);
        logic [7:0] d;
        logic [7:0] b;
        d    = s[9] ? ~s[7:0] : s[7:0];     // Undo the DC inversion
        b[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? d[i] ^ d[i-1] : ~(d[i] ^ d[i-1]);
        end
        return b;
    endfunction

    // Bit 8 must match the XOR or XNOR choice the byte calls for
    function automatic logic valid_form(input logic [7:0] b, input logic xor_flag);
        int n1;
        n1 = count_ones({2'b00, b});
        return xor_flag == !((n1 > 4) || (n1 == 4 && !b[0]));
    endfunction

    // Colour field to 8 bits, top bits repeated below
    function automatic logic [7:0] widen(input logic [5:0] field, input int width);
        logic [7:0] r;
        r = 8'(field) << (8 - width);
        r = r | (r >> width);
        return r;
    endfunction

    function automatic video_pkg::video_ctrl_t expected_ctrl(input int h, input int v);
        video_pkg::video_ctrl_t c;
        c.de    = (h < H_ACTIVE) && (v < V_ACTIVE);
        c.hsync = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        c.vsync = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        return c;
    endfunction

    // ********************
    // Checks
    // ********************

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first failing check");
    endtask

    task automatic compare_sym(input string test, input tmds_pkg::tmds_sym_t exp,
                               input tmds_pkg::tmds_sym_t act);
        if (exp !== act) begin
            stop_run($sformatf("ERROR %s: symbol expected %b actual %b", test, exp, act));
        end
    endtask

    task automatic compare_pixel(input string test, input video_pkg::rgb565_t exp,
                                 input video_pkg::rgb565_t act);
        if (exp !== act) begin
            stop_run($sformatf("ERROR %s: pixel expected %h actual %h", test, exp, act));
        end
    endtask

    // Printed as {hsync, vsync, de}
    task automatic compare_ctrl(input string test, input video_pkg::video_ctrl_t exp,
                                input video_pkg::video_ctrl_t act);
        if (exp !== act) begin
            stop_run($sformatf("ERROR %s: ctrl expected %b actual %b", test, exp, act));
        end
    endtask

    task automatic compare_chan(input string test, input tmds_pkg::tmds_in_t exp,
                                input tmds_pkg::tmds_in_t act);
        if (exp !== act) begin
            stop_run($sformatf("ERROR %s: channel expected %h actual %h", test, exp, act));
        end
    endtask

    task automatic compare_count(input string test, input string what, input int exp,
                                 input int act);
        if (exp != act) begin
            stop_run($sformatf("ERROR %s: %s expected %0d actual %0d", test, what, exp, act));
        end
    endtask

    // ********************
    // Stimulus and symbol stream
    // ********************

    task automatic pop_syms(input string test, output sym_triple_t s);
        int waited;
        waited = 0;
        while (sym_q.size() == 0) begin
            @(posedge pixel_clk);
            waited++;
            if (waited > WAIT_MAX) begin
                stop_run({test, ": no TMDS symbols arrive on the lanes"});
            end
        end
        s = sym_q.pop_front();
    endtask

    // Leaves the first active pixel after a vsync in pending
    task automatic sync_frame(input string test);
        sym_triple_t s;
        int          tok;
        int          n;
        n = 0;
        do begin
            pop_syms(test, s);
            tok = find_token(s.ch0);
            n++;
            if (n > 2 * FRAME) begin
                stop_run({test, ": no vsync found on channel 0"});
            end
        end while (tok < 2);            // Index 2 and 3 carry vsync
        do begin
            pop_syms(test, s);
            tok = find_token(s.ch0);
            n++;
            if (n > 3 * FRAME) begin
                stop_run({test, ": no active video after vsync"});
            end
        end while (tok >= 0);
        pending = s;
    endtask

    task automatic write_frame();
        video_pkg::cam_word_u cam_word;
        @(negedge pixel_clk);
        cam_vsync = 1'b1;               // Rising edge restarts the address
        repeat (2) @(negedge pixel_clk);
        cam_vsync = 1'b0;
        repeat (2) @(negedge pixel_clk);
        for (int a = 0; a < PIXELS; a++) begin
            cam_word.pix = image[a];
            cam_href     = 1'b1;
            cam_data     = cam_word.bytes.hi_byte;
            @(negedge pixel_clk);
            cam_data = cam_word.bytes.lo_byte;
            @(negedge pixel_clk);
            if (a % H_ACTIVE == H_ACTIVE - 1) begin
                cam_href = 1'b0;        // Line gap
                cam_data = 8'h00;
                repeat (3) @(negedge pixel_clk);
            end
        end
    endtask

    // Checks one whole frame starting at pending
    task automatic read_frame(input string test);
        sym_triple_t            s;
        tmds_pkg::tmds_sym_t    sy [3];
        video_pkg::video_ctrl_t exp_ctrl;
        video_pkg::video_ctrl_t act_ctrl;
        video_pkg::rgb565_t     exp_pix;
        video_pkg::rgb565_t     act_pix;
        tmds_pkg::tmds_in_t     exp_in;
        tmds_pkg::tmds_in_t     act_in;
        logic [7:0]             byte_val [3];
        logic [7:0]             exp_byte [3];
        int                     disp [3];   // Running ones minus zeros
        int                     tok;
        int                     hs_len;
        int                     data_len;
        logic                   prev_hs;
        logic                   prev_de;
        s                  = pending;
        disp               = '{0, 0, 0};
        hs_len             = 0;
        data_len           = 0;
        prev_hs            = 1'b0;
        prev_de            = 1'b0;
        frame_lines        = 0;
        frame_active_lines = 0;
        for (int k = 0; k < FRAME; k++) begin
            if (k > 0) begin
                pop_syms(test, s);
            end
            sy       = '{s.ch0, s.ch1, s.ch2};
            tok      = find_token(sy[0]);
            exp_ctrl = expected_ctrl(k % H_TOTAL, k / H_TOTAL);
            act_ctrl = '{hsync: tok >= 0 && tok[0], vsync: tok >= 0 && tok[1], de: tok < 0};
            compare_ctrl(test, exp_ctrl, act_ctrl);
            if (!exp_ctrl.de) begin
                compare_sym(test, tmds_pkg::CTRL_TOKEN[{exp_ctrl.vsync, exp_ctrl.hsync}],
                            sy[0]);
                compare_sym(test, tmds_pkg::CTRL_TOKEN[0], sy[1]);
                compare_sym(test, tmds_pkg::CTRL_TOKEN[0], sy[2]);
                disp = '{0, 0, 0};      // Balance restarts in blanking
            end else begin
                exp_pix  = image[(k / H_TOTAL) * H_ACTIVE + k % H_TOTAL];
                exp_byte = '{widen(exp_pix.blue, 5), widen(exp_pix.green, 6),
                             widen(exp_pix.red, 5)};
                for (int c = 0; c < 3; c++) begin
                    byte_val[c] = decode_byte(sy[c]);
                    if (!valid_form(byte_val[c], sy[c][8])) begin
                        stop_run($sformatf("%s: channel %0d symbol %b is not a TMDS data code",
                                           test, c, sy[c]));
                    end
                    disp[c] += 2 * count_ones(sy[c]) - 10;
                    if (disp[c] > 10 || disp[c] < -10) begin
                        stop_run($sformatf("ERROR %s: channel %0d disparity expected %s actual %0d",
                                           test, c, "within 10", disp[c]));
                    end
                end
                // Top bits carry the stored pixel
                act_pix = '{red: byte_val[2][7:3], green: byte_val[1][7:2],
                            blue: byte_val[0][7:3]};
                compare_pixel(test, exp_pix, act_pix);
                // Low bits must repeat the top bits
                for (int c = 0; c < 3; c++) begin
                    exp_in = '{data: exp_byte[c], ctrl: 2'b00, de: 1'b1};
                    act_in = '{data: byte_val[c], ctrl: 2'b00, de: 1'b1};
                    compare_chan(test, exp_in, act_in);
                end
            end
            // Pulse and line lengths, counted at their falling end
            if (act_ctrl.hsync) begin
                hs_len++;
            end else if (prev_hs) begin
                compare_count(test, "hsync width", H_SYNC, hs_len);
                frame_lines++;
                hs_len = 0;
            end
            if (act_ctrl.de) begin
                data_len++;
            end else if (prev_de) begin
                compare_count(test, "line length", H_ACTIVE, data_len);
                frame_active_lines++;
                data_len = 0;
            end
            prev_hs = act_ctrl.hsync;
            prev_de = act_ctrl.de;
        end
        pop_syms(test, pending);        // Origin of the following frame
    endtask

    // Load image through the camera, then check the next full frame
    task automatic show_frame(input string test);
        write_frame();
        sym_q.delete();                 // Drop symbols from before the write
        sync_frame(test);
        read_frame(test);
    endtask

    // ********************
    // Directed tests
    // ********************

    task automatic pixel_path();
        for (int a = 0; a < PIXELS; a++) begin
            image[a] = video_pkg::rgb565_t'(16'(a * 16'h9e37 + 16'h1234));
        end
        show_frame("pixel_path");
    endtask

    task automatic blanking_tokens();
        read_frame("blanking_tokens");
    endtask

    task automatic raster_shape();
        read_frame("raster_shape");
        compare_count("raster_shape", "lines per frame", V_TOTAL, frame_lines);
        compare_count("raster_shape", "active lines", V_ACTIVE, frame_active_lines);
    endtask

    task automatic random_overwrite();
        for (int a = 0; a < PIXELS; a++) begin
            image[a] = video_pkg::rgb565_t'(16'($urandom()));
        end
        show_frame("random_overwrite");
    endtask

    // Full scale, zero and random pixels mixed to push the disparity
    task automatic dc_balance();
        for (int a = 0; a < PIXELS; a++) begin
            if (a % 3 == 0) begin
                image[a] = video_pkg::rgb565_t'(16'hffff);
            end else if (a % 3 == 1) begin
                image[a] = video_pkg::rgb565_t'(16'h0000);
            end else begin
                image[a] = video_pkg::rgb565_t'(16'($urandom()));
            end
        end
        show_frame("dc_balance");
        read_frame("dc_balance");
    endtask

    initial begin
        void'($urandom(99));
        rst_n     = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = 8'h00;
        repeat (4) @(negedge pixel_clk);
        rst_n = 1'b1;
        pixel_path();
        blanking_tokens();
        raster_shape();
        random_overwrite();
        dc_balance();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/ov5640_hdmi.sv
/* Camera to HDMI top level. Captures the camera stream into an on-chip frame
   buffer and displays it through three TMDS encoders and a DDR serializer */
`timescale 1ns/1ps
`default_nettype none

module ov5640_hdmi #(
    parameter int H_ACTIVE = 1024,
    parameter int H_FRONT  = 24,
    parameter int H_SYNC   = 136,
    parameter int H_BACK   = 1056,      // Line total 2240
    parameter int V_ACTIVE = 768,
    parameter int V_FRONT  = 3,
    parameter int V_SYNC   = 6,
    parameter int V_BACK   = 495        // Frame total 1272 lines
) (
    input  logic       pixel_clk,
    input  logic       pixel_clk_5x,   // Five times pixel_clk, edge aligned
    input  logic       rst_n,
    input  logic       cam_vsync,
    input  logic       cam_href,
    input  logic [7:0] cam_data,
    output logic       tmds_clk,
    output logic [2:0] tmds_data
);

    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);

    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    logic [ADDR_W-1:0]   rd_addr;
    video_pkg::rgb565_t  wr_pixel;
    video_pkg::rgb565_t  rd_pixel;
    tmds_pkg::tmds_in_t  chan [3];      // 0 blue, 1 green, 2 red
    tmds_pkg::tmds_sym_t sym [3];

    // ********************
    // Capture and store
    // ********************

    cmos_capture #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_cmos_capture (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n    ),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href ),
        .cam_data  (cam_data ),
        .wr_en     (wr_en    ),
        .wr_addr   (wr_addr  ),
        .wr_pixel  (wr_pixel )
    );

    frame_buffer #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_frame_buffer (
        .pixel_clk (pixel_clk),
        .wr_en     (wr_en    ),
        .wr_addr   (wr_addr  ),
        .wr_pixel  (wr_pixel ),
        .rd_addr   (rd_addr  ),
        .rd_pixel  (rd_pixel )
    );

    // ********************
    // Display side
    // ********************

    video_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_video_timing (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n    ),
        .rd_addr   (rd_addr  ),
        .rd_pixel  (rd_pixel ),
        .chan      (chan     )
    );

    for (genvar i = 0; i < 3; i++) begin : g_chan
        tmds_encoder u_tmds_encoder (
            .pixel_clk (pixel_clk),
            .rst_n     (rst_n    ),
            .din       (chan[i]  ),
            .sym       (sym[i]   )
        );
    end

    tmds_serializer u_tmds_serializer (
        .pixel_clk    (pixel_clk   ),
        .pixel_clk_5x (pixel_clk_5x),
        .rst_n        (rst_n       ),
        .sym          (sym         ),
        .tmds_data    (tmds_data   ),
        .tmds_clk     (tmds_clk    )
    );

endmodule

`default_nettype wire

// File: hdl/tmds_serializer.sv
/* 10:1 DDR serializer for three TMDS data lanes and the clock lane.
   Symbols taken on pixel_clk go out LSB first on both pixel_clk_5x edges */
`timescale 1ns/1ps
`default_nettype none

module tmds_serializer (
    input  logic                pixel_clk,
    input  logic                pixel_clk_5x,
    input  logic                rst_n,
    input  tmds_pkg::tmds_sym_t sym [3],
    output logic [2:0]          tmds_data,
    output logic                tmds_clk
);

    // Five ones then five zeros in time order
    localparam tmds_pkg::tmds_sym_t CLK_PATTERN = 10'b00000_11111;

    tmds_pkg::tmds_sym_t sym_hold [3];  // Held for one pixel period
    logic                load_tgl;      // Flips on every pixel_clk edge
    logic                tgl_d;
    logic                tgl_seen;      // First fast edge of a pixel period
    logic [2:0]          slot;          // Fast cycle within the pixel period
    tmds_pkg::tmds_sym_t shift [4];     // 0..2 data, 3 clock
    logic [3:0]          lane_out;

    // ********************
    // Pixel clock side
    // ********************

    always_ff @(posedge pixel_clk) begin
        sym_hold <= sym;
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            load_tgl <= 1'b0;
        end else begin
            load_tgl <= ~load_tgl;
        end
    end

    // ********************
    // Fast clock side
    // ********************

    assign tgl_seen = load_tgl ^ tgl_d;

    always_ff @(posedge pixel_clk_5x) begin
        if (!rst_n) begin
            tgl_d <= 1'b0;
            slot  <= '0;
            for (int i = 0; i < 4; i++) begin
                shift[i] <= '0;
            end
        end else begin
            tgl_d <= load_tgl;
            if (tgl_seen) begin
                slot <= 3'd1;           // Re-align once per pixel
            end else if (slot == 3'd4) begin
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
            if (slot == 3'd4) begin
                // Lands on the pixel_clk edge, takes the previous hold
                for (int i = 0; i < 3; i++) begin
                    shift[i] <= sym_hold[i];
                end
                shift[3] <= CLK_PATTERN;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    shift[i] <= shift[i] >> 2;  // Two bits per fast cycle
                end
            end
        end
    end

    // Rise/fall mux, even bit in the high half
    for (genvar i = 0; i < 4; i++) begin : g_lane
        assign lane_out[i] = pixel_clk_5x ? shift[i][0] : shift[i][1];
    end

    assign tmds_data = lane_out[2:0];
    assign tmds_clk  = lane_out[3];

endmodule

`default_nettype wire

// File: hdl/tmds_encoder.sv
/* One DVI TMDS channel encoder, 8b/10b with running disparity.
   Two pipeline stages, control tokens sent while de is low */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
    input  logic                pixel_clk,
    input  logic                rst_n,
    input  tmds_pkg::tmds_in_t  din,
    output tmds_pkg::tmds_sym_t sym
);

    // Population count of one byte
    function automatic logic [3:0] count_ones(input logic [7:0] value);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + 4'(value[i]);
        end
        return n;
    endfunction

    logic [3:0]          n1_d;          // Ones in the input byte
    logic                use_xnor;
    logic [8:0]          q_m_next;
    logic [8:0]          q_m;           // Transition-minimised word
    logic                de_q;
    logic [1:0]          ctrl_q;
    logic [3:0]          n1_q;          // Ones in q_m[7:0]
    logic signed [5:0]   bal;           // Ones minus zeros of q_m[7:0]
    logic signed [5:0]   cnt;           // Running disparity
    logic signed [5:0]   cnt_next;
    tmds_pkg::tmds_sym_t sym_next;

    // ********************
    // Stage 1, minimise transitions
    // ********************

    always_comb begin
        n1_d        = count_ones(din.data);
        use_xnor    = (n1_d > 4'd4) || (n1_d == 4'd4 && !din.data[0]);
        q_m_next[0] = din.data[0];
        for (int i = 1; i < 8; i++) begin
            q_m_next[i] = use_xnor ? ~(q_m_next[i-1] ^ din.data[i])
                                   :  (q_m_next[i-1] ^ din.data[i]);
        end
        q_m_next[8] = ~use_xnor;        // 1 marks the XOR form
    end

    always_ff @(posedge pixel_clk) begin
        q_m <= q_m_next;
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            de_q   <= 1'b0;
            ctrl_q <= 2'b00;
        end else begin
            de_q   <= din.de;
            ctrl_q <= din.ctrl;
        end
    end

    // ********************
    // Stage 2, DC balance
    // ********************

    always_comb begin
        n1_q = count_ones(q_m[7:0]);
        bal  = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;     // 2*n1 - 8
        if (cnt == 0 || bal == 0) begin
            // No bias either way, bit 9 flags the inversion
            sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_next = q_m[8] ? cnt + bal : cnt - bal;
        end else if ((cnt > 0 && bal > 0) || (cnt < 0 && bal < 0)) begin
            sym_next = {1'b1, q_m[8], ~q_m[7:0]};       // Invert to pull back
            cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
        end else begin
            sym_next = {1'b0, q_m[8], q_m[7:0]};
            cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            cnt <= '0;
            sym <= tmds_pkg::CTRL_TOKEN[0];
        end else if (!de_q) begin
            cnt <= '0;                  // Blanking restarts the balance
            sym <= tmds_pkg::CTRL_TOKEN[ctrl_q];
        end else begin
            cnt <= cnt_next;
            sym <= sym_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/video_timing.sv
/* Raster timing generator. Scans the frame buffer and feeds the three TMDS
   channels with expanded pixel bytes, syncs and data enable */
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter  int H_ACTIVE = 1024,
    parameter  int H_FRONT  = 24,
    parameter  int H_SYNC   = 136,
    parameter  int H_BACK   = 1056,
    parameter  int V_ACTIVE = 768,
    parameter  int V_FRONT  = 3,
    parameter  int V_SYNC   = 6,
    parameter  int V_BACK   = 495,
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK,
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK,
    localparam int H_W      = $clog2(H_TOTAL),
    localparam int V_W      = $clog2(V_TOTAL),
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic               pixel_clk,
    input  logic               rst_n,
    output logic [ADDR_W-1:0]  rd_addr,
    input  video_pkg::rgb565_t rd_pixel,
    output tmds_pkg::tmds_in_t chan [3]   // 0 blue, 1 green, 2 red
);

    logic [H_W-1:0]         h_cnt;      // 0 is the first active pixel
    logic [V_W-1:0]         v_cnt;
    video_pkg::video_ctrl_t ctrl_now;   // Decoded from the counters
    video_pkg::video_ctrl_t ctrl_d1;    // Lined up with rd_pixel

    // ********************
    // Raster counters
    // ********************

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_W'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Active area first, then front porch, sync, back porch
    always_comb begin
        ctrl_now.de    = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
        ctrl_now.hsync = (h_cnt >= H_ACTIVE + H_FRONT) &&
                         (h_cnt <  H_ACTIVE + H_FRONT + H_SYNC);
        ctrl_now.vsync = (v_cnt >= V_ACTIVE + V_FRONT) &&
                         (v_cnt <  V_ACTIVE + V_FRONT + V_SYNC);
    end

    // Linear address, parked at zero in blanking
    assign rd_addr = ctrl_now.de ? ADDR_W'(v_cnt * H_ACTIVE + h_cnt) : '0;

    // Match the buffer read latency
    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            ctrl_d1 <= '0;
        end else begin
            ctrl_d1 <= ctrl_now;
        end
    end

    // ********************
    // Channel feed
    // ********************

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            chan[0] <= '0;
            chan[1] <= '0;
            chan[2] <= '0;
        end else begin
            chan[0] <= '{data: video_pkg::expand_565(rd_pixel.blue, 5),
                         ctrl: {ctrl_d1.vsync, ctrl_d1.hsync},   // Syncs ride on blue
                         de:   ctrl_d1.de};
            chan[1] <= '{data: video_pkg::expand_565(rd_pixel.green, 6),
                         ctrl: 2'b00,
                         de:   ctrl_d1.de};
            chan[2] <= '{data: video_pkg::expand_565(rd_pixel.red, 5),
                         ctrl: 2'b00,
                         de:   ctrl_d1.de};
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_buffer.sv
/* On-chip frame store for one RGB565 frame.
   Written by the capture side, read by the raster with one cycle latency */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter  int H_ACTIVE = 1024,
    parameter  int V_ACTIVE = 768,
    localparam int DEPTH    = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W   = $clog2(DEPTH)
) (
    input  logic               pixel_clk,
    input  logic               wr_en,
    input  logic [ADDR_W-1:0]  wr_addr,
    input  video_pkg::rgb565_t wr_pixel,
    input  logic [ADDR_W-1:0]  rd_addr,
    output video_pkg::rgb565_t rd_pixel
);

    video_pkg::rgb565_t mem [DEPTH];    // One word per displayed pixel

    // Write port
    always_ff @(posedge pixel_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_pixel;
        end
    end

    // Read port, registered
    // Same-address collision returns the old word
    always_ff @(posedge pixel_clk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/cmos_capture.sv
/* Camera byte capture. Pairs bytes into RGB565 pixels while href is high and
   writes them into the frame buffer in raster order, restarting at each vsync */
`timescale 1ns/1ps
`default_nettype none

module cmos_capture #(
    parameter  int H_ACTIVE = 1024,
    parameter  int V_ACTIVE = 768,
    localparam int DEPTH    = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W   = $clog2(DEPTH)
) (
    input  logic               pixel_clk,
    input  logic               rst_n,
    input  logic               cam_vsync,
    input  logic               cam_href,
    input  logic [7:0]         cam_data,
    output logic               wr_en,
    output logic [ADDR_W-1:0]  wr_addr,
    output video_pkg::rgb565_t wr_pixel
);

    logic                 vsync_d;      // Previous vsync level
    logic                 vsync_rise;   // Start of a new camera frame
    logic                 byte_phase;   // 0 waits for high byte, 1 for low byte
    video_pkg::cam_word_u word_q;       // Pixel under assembly

    assign vsync_rise = cam_vsync & ~vsync_d;

    // Edge detect and byte phase
    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            vsync_d    <= 1'b0;
            byte_phase <= 1'b0;
        end else begin
            vsync_d <= cam_vsync;
            if (vsync_rise || !cam_href) begin
                byte_phase <= 1'b0;     // Every line starts on a high byte
            end else begin
                byte_phase <= ~byte_phase;
            end
        end
    end

    // Byte slots of the word
    always_ff @(posedge pixel_clk) begin
        if (cam_href) begin
            if (!byte_phase) begin
                word_q.bytes.hi_byte <= cam_data;
            end else begin
                word_q.bytes.lo_byte <= cam_data;
            end
        end
    end

    // ********************
    // Write strobe and address
    // ********************

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en <= cam_href & byte_phase & ~vsync_rise;   // Pulse after low byte
            if (vsync_rise) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= (wr_addr == ADDR_W'(DEPTH - 1)) ? '0 : wr_addr + 1'b1;
            end
        end
    end

    assign wr_pixel = word_q.pix;       // Same word, pixel view

endmodule

`default_nettype wire

// File: hdl/tmds_pkg.sv
/* TMDS channel types and DVI control tokens.
   Used by the timing generator, the channel encoders and the serializer */
`default_nettype none

package tmds_pkg;

    // Input of one channel encoder
    typedef struct packed {
        logic [7:0] data;           // Pixel byte, valid while de is high
        logic [1:0] ctrl;           // {c1, c0}, sent in blanking
        logic       de;
    } tmds_in_t;

    typedef logic [9:0] tmds_sym_t; // Bit 0 goes out first

    // ********************
    // Control tokens
    // ********************

    // Indexed by the ctrl value
    localparam tmds_sym_t CTRL_TOKEN [4] = '{
        10'b1101010100,             // 2'b00
        10'b0010101011,             // 2'b01
        10'b0101010100,             // 2'b10
        10'b1010101011              // 2'b11
    };

endpackage

`default_nettype wire

// File: hdl/video_pkg.sv
/* Pixel, camera word and sync types shared by the capture and display side.
   Modules refer to these through video_pkg:: scoped names */
`default_nettype none

package video_pkg;

    // ********************
    // Pixel and camera word
    // ********************

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;                     // Frame buffer word

    typedef struct packed {
        logic [7:0] hi_byte;        // Arrives first on the camera bus
        logic [7:0] lo_byte;
    } cam_bytes_t;

    // One 16-bit word, filled byte by byte, read back as a pixel
    typedef union packed {
        rgb565_t    pix;
        cam_bytes_t bytes;
    } cam_word_u;

    typedef struct packed {
        logic hsync;                // Active high
        logic vsync;                // Active high
        logic de;                   // Active video
    } video_ctrl_t;

    // Widen a 5 or 6 bit colour field to 8 bits
    // Top bits repeat into the bottom so full scale maps to 8'hff
    function automatic logic [7:0] expand_565(input logic [5:0] chan, input int unsigned width);
        logic [7:0] result;
        if (width == 5) begin
            result = {chan[4:0], chan[4:2]};
        end else begin
            result = {chan[5:0], chan[5:4]};
        end
        return result;
    endfunction

endpackage

`default_nettype wire
